// ==== filelist.f ====
+incdir+common
common/ntm_diff_pkg.sv
source/ntm_scalar_mod_diff.sv
vector_differentiation/ntm_vector_differentiation.sv
source/ntm_differentiation_top.sv
sim/ntm_differentiation_checker.sv
sim/ntm_differentiation_tb.sv

// ==== Bender.yml ====
package:
  name: ntm_differentiation

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/ntm_diff_pkg.sv
      - source/ntm_scalar_mod_diff.sv
      - vector_differentiation/ntm_vector_differentiation.sv
      - source/ntm_differentiation_top.sv

  - target: simulation
    include_dirs:
      - common
    files:
      - sim/ntm_differentiation_checker.sv
      - sim/ntm_differentiation_tb.sv

// ==== sim/ntm_differentiation_tb.sv ====
//////////////////////////////
// Table-driven testbench of the modular first difference
// Each row is one vector, results compared with a reference model
//////////////////////////////

`include "ntm_diff_params.svh"

module ntm_differentiation_tb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_ROWS  = 8;
  localparam int MAX_ELEMS = 8;
  // Generous bound on each wait for a result
  localparam int TIMEOUT   = 4 * `NTM_DIFF_TOTAL_LATENCY;

  //////////////////////////////
  // DUT signals
  //////////////////////////////

  logic                 CLK;
  logic                 RST;
  logic                 start;
  ntm_diff_pkg::index_t size;
  ntm_diff_pkg::data_t  modulo;
  ntm_diff_pkg::data_t  data_in;
  logic                 data_in_enable;
  ntm_diff_pkg::data_t  data_out;
  logic                 data_out_enable;
  logic                 ready;

  //////////////////////////////
  // Stimulus table
  //////////////////////////////

  string                row_name   [NUM_ROWS];
  ntm_diff_pkg::index_t row_size   [NUM_ROWS];
  ntm_diff_pkg::data_t  row_mod    [NUM_ROWS];
  // Fill elements from $random
  bit                   row_random [NUM_ROWS];
  // Pulse start again in mid-vector
  bit                   row_restart[NUM_ROWS];
  ntm_diff_pkg::data_t  row_elem   [NUM_ROWS][MAX_ELEMS];

  integer seed = 32'h8559b84b;

  ntm_differentiation_top dut_i (
    .CLK             (CLK),
    .RST             (RST),
    .start           (start),
    .size            (size),
    .modulo          (modulo),
    .data_in         (data_in),
    .data_in_enable  (data_in_enable),
    .data_out        (data_out),
    .data_out_enable (data_out_enable),
    .ready           (ready)
  );

  // 20 ns clock
  initial begin
    CLK = 1'b0;
    forever begin
      #10 CLK = ~CLK;
    end
  end

  //////////////////////////////
  // Reference model and helpers
  //////////////////////////////

  // (a - b) mod m with both operands reduced first
  function automatic ntm_diff_pkg::data_t expected_difference(
    input ntm_diff_pkg::data_t a,
    input ntm_diff_pkg::data_t b,
    input ntm_diff_pkg::data_t m
  );
    logic [`NTM_DIFF_DATA_WIDTH:0] sum;
    sum = {1'b0, a % m} + {1'b0, m} - {1'b0, b % m};
    if (sum >= {1'b0, m}) begin
      sum = sum - {1'b0, m};
    end
    return sum[`NTM_DIFF_DATA_WIDTH-1:0];
  endfunction

  task automatic check_value(input string name, input ntm_diff_pkg::data_t expected,
                             input ntm_diff_pkg::data_t actual);
    if (expected !== actual) begin
      $display("CHECK FAILED: %s expected %h actual %h", name, expected, actual);
      $display("STATUS: FAIL");
      $fatal(1, "mismatch in %s", name);
    end
  endtask

  task automatic report_timeout(input string what);
    $display("Timed out after %0d cycles waiting for %s", TIMEOUT, what);
    $display("STATUS: FAIL");
    $fatal(1, "timeout");
  endtask

  // Sample on the falling edge, outputs are stable there
  task automatic wait_output(input string name);
    int cycles;
    cycles = 0;
    @(negedge CLK);
    while (!data_out_enable) begin
      if (cycles >= TIMEOUT) begin
        report_timeout({"data_out_enable in ", name});
      end
      cycles = cycles + 1;
      @(negedge CLK);
    end
  endtask

  task automatic load_table();
    row_name[0] = "first_element_size1";
    row_size[0] = 1;
    row_mod[0]  = 1000;
    row_elem[0] = '{1234, 0, 0, 0, 0, 0, 0, 0};

    row_name[1] = "increasing_size7";
    row_size[1] = 7;
    row_mod[1]  = 32'h7fff_ffff;
    row_elem[1] = '{5, 10, 20, 40, 80, 160, 320, 0};

    row_name[2] = "decreasing_wrap_size2";
    row_size[2] = 2;
    row_mod[2]  = 97;
    row_elem[2] = '{50, 20, 0, 0, 0, 0, 0, 0};

    row_name[3] = "decreasing_steps";
    row_size[3] = 6;
    row_mod[3]  = 1000;
    row_elem[3] = '{900, 700, 701, 3, 999, 0, 0, 0};

    row_name[4] = "random_mod13";
    row_size[4] = 7;
    row_mod[4]  = 13;
    row_random[4] = 1'b1;

    row_name[5] = "random_mod3";
    row_size[5] = 5;
    row_mod[5]  = 3;
    row_random[5] = 1'b1;

    // Stray start with a zero modulus must be ignored
    row_name[6] = "restart_ignored";
    row_size[6] = 4;
    row_mod[6]  = 251;
    row_elem[6] = '{200, 7, 255, 100, 0, 0, 0, 0};
    row_restart[6] = 1'b1;

    // Size zero runs as one element
    row_name[7] = "size_zero";
    row_size[7] = 0;
    row_mod[7]  = 5;
    row_elem[7] = '{17, 0, 0, 0, 0, 0, 0, 0};

    for (int r = 0; r < NUM_ROWS; r++) begin
      if (row_random[r]) begin
        for (int i = 0; i < MAX_ELEMS; i++) begin
          row_elem[r][i] = $random(seed);
        end
      end
    end
  endtask

  //////////////////////////////
  // One vector
  //////////////////////////////

  task automatic apply_vector(input int r);
    int                  count;
    ntm_diff_pkg::data_t prev;
    ntm_diff_pkg::data_t expected;
    string               name;
    count = (row_size[r] == 0) ? 1 : int'(row_size[r]);
    prev  = '0;

    @(posedge CLK);
    start  <= 1'b1;
    size   <= row_size[r];
    modulo <= row_mod[r];
    @(posedge CLK);
    start  <= 1'b0;

    for (int i = 0; i < count; i++) begin
      name = $sformatf("%s[%0d]", row_name[r], i);
      expected = expected_difference(row_elem[r][i], prev, row_mod[r]);
      prev = row_elem[r][i];

      @(posedge CLK);
      data_in        <= row_elem[r][i];
      data_in_enable <= 1'b1;
      @(posedge CLK);
      data_in_enable <= 1'b0;

      // Controller is busy with the scalar unit here
      if (row_restart[r] && (i == 1)) begin
        start  <= 1'b1;
        size   <= 1;
        modulo <= '0;
        @(posedge CLK);
        start  <= 1'b0;
      end

      wait_output(name);
      check_value({name, " data_out"}, expected, data_out);
      check_value({name, " ready"}, ntm_diff_pkg::data_t'(i == count - 1),
                  ntm_diff_pkg::data_t'(ready));
    end
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin
    RST            = 1'b1;
    start          = 1'b0;
    size           = '0;
    modulo         = '0;
    data_in        = '0;
    data_in_enable = 1'b0;
    for (int r = 0; r < NUM_ROWS; r++) begin
      row_random[r]  = 1'b0;
      row_restart[r] = 1'b0;
    end
    load_table();

    repeat (10) @(posedge CLK);
    RST <= 1'b0;
    repeat (2) @(posedge CLK);

    for (int r = 0; r < NUM_ROWS; r++) begin
      apply_vector(r);
    end

    repeat (5) @(posedge CLK);
    if (dut_i.checker_i.error_count != 0) begin
      $display("Bound checker reported %0d assertion failures",
               dut_i.checker_i.error_count);
      $display("STATUS: FAIL");
      $fatal(1, "assertion failures");
    end else begin
      $display("STATUS: PASS");
      $finish;
    end
  end

endmodule

// ==== sim/ntm_differentiation_checker.sv ====
//////////////////////////////
// Protocol and range assertions of the first-difference top level
// Bound to ntm_differentiation_top, counts every failed property
//////////////////////////////

module ntm_differentiation_checker (
  input logic                CLK,
  input logic                RST,
  input logic                start,
  input ntm_diff_pkg::data_t modulo,
  input ntm_diff_pkg::data_t data_out,
  input logic                data_out_enable,
  input logic                ready
);

  timeunit 1ns;
  timeprecision 1ps;

  // Vector in progress, mirrors the controller leaving IDLE
  logic                busy;
  // Modulus of the running vector
  ntm_diff_pkg::data_t cap_modulus;
  // Start seen while the controller is idle
  logic                start_taken;
  // Read by the testbench at the end of the run
  int unsigned         error_count = 0;

  // Controller is back in IDLE in the cycle ready is high
  assign start_taken = start && (!busy || ready);

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      busy        <= 1'b0;
      cap_modulus <= '0;
    end else if (start_taken) begin
      busy        <= 1'b1;
      cap_modulus <= modulo;
    end else if (ready) begin
      busy        <= 1'b0;
    end
  end

  //////////////////////////////
  // Properties
  //////////////////////////////

  // Output strobe lasts one cycle
  single_pulse_a: assert property (@(posedge CLK) disable iff (RST)
    data_out_enable |=> !data_out_enable)
    else begin
      error_count = error_count + 1;
      $error("data_out_enable stayed high for more than one cycle");
    end

  // Last-result flag only with a result
  ready_with_output_a: assert property (@(posedge CLK) disable iff (RST)
    ready |-> data_out_enable)
    else begin
      error_count = error_count + 1;
      $error("ready pulsed without data_out_enable");
    end

  // Modulus of zero is outside the input range
  nonzero_modulus_a: assert property (@(posedge CLK) disable iff (RST)
    start_taken |-> (modulo != '0))
    else begin
      error_count = error_count + 1;
      $error("start accepted with a modulus of zero");
    end

  // Result lies in 0 to m-1
  result_range_a: assert property (@(posedge CLK) disable iff (RST)
    data_out_enable |-> (data_out < cap_modulus))
    else begin
      error_count = error_count + 1;
      $error("data_out not below the captured modulus");
    end

endmodule

bind ntm_differentiation_top ntm_differentiation_checker checker_i (
  .CLK             (CLK),
  .RST             (RST),
  .start           (start),
  .modulo          (modulo),
  .data_out        (data_out),
  .data_out_enable (data_out_enable),
  .ready           (ready)
);

// ==== source/ntm_differentiation_top.sv ====
//////////////////////////////
// First difference of a vector modulo m
// Vector controller in front of one scalar modular difference unit
//////////////////////////////

module ntm_differentiation_top (
  // Global
  input  logic                  CLK,
  input  logic                  RST,

  // Vector control
  input  logic                  start,
  input  ntm_diff_pkg::index_t  size,
  input  ntm_diff_pkg::data_t   modulo,

  // Element stream
  input  ntm_diff_pkg::data_t   data_in,
  input  logic                  data_in_enable,
  output ntm_diff_pkg::data_t   data_out,
  output logic                  data_out_enable,
  output logic                  ready
);

  // Controller to scalar unit
  logic                        scalar_start;
  ntm_diff_pkg::mod_operands_t operands;
  // Scalar unit back to controller
  logic                        scalar_done;
  ntm_diff_pkg::data_t         difference;

  // Sequencing and result registers
  ntm_vector_differentiation vector_i (
    .CLK             (CLK),
    .RST             (RST),
    .start           (start),
    .size            (size),
    .modulo          (modulo),
    .data_in         (data_in),
    .data_in_enable  (data_in_enable),
    .data_out        (data_out),
    .data_out_enable (data_out_enable),
    .ready           (ready),
    .scalar_start    (scalar_start),
    .operands        (operands),
    .scalar_done     (scalar_done),
    .difference      (difference)
  );

  // Bit-serial modular difference
  ntm_scalar_mod_diff scalar_i (
    .CLK          (CLK),
    .RST          (RST),
    .scalar_start (scalar_start),
    .scalar_done  (scalar_done),
    .operands     (operands),
    .difference   (difference)
  );

endmodule

// ==== vector_differentiation/ntm_vector_differentiation.sv ====
//////////////////////////////
// Vector controller of the first difference
// Takes elements one at a time, feeds the scalar unit with the
// new and previous element, registers each result and flags the last
//////////////////////////////

module ntm_vector_differentiation (
  // Global
  input  logic                          CLK,
  input  logic                          RST,

  // Vector control
  input  logic                          start,
  input  ntm_diff_pkg::index_t          size,
  input  ntm_diff_pkg::data_t           modulo,

  // Element stream
  input  ntm_diff_pkg::data_t           data_in,
  input  logic                          data_in_enable,
  output ntm_diff_pkg::data_t           data_out,
  output logic                          data_out_enable,
  output logic                          ready,

  // Scalar unit side
  output logic                          scalar_start,
  output ntm_diff_pkg::mod_operands_t   operands,
  input  logic                          scalar_done,
  input  ntm_diff_pkg::data_t           difference
);

  //////////////////////////////
  // Signals
  //////////////////////////////

  // Controller state
  ntm_diff_pkg::vec_state_e state;

  // Vector length and current position
  ntm_diff_pkg::index_t length;
  ntm_diff_pkg::index_t index;

  // Modulus of the running vector
  ntm_diff_pkg::data_t modulus;

  // Element x[i-1], zero before the first one
  ntm_diff_pkg::data_t prev_element;

  // Accept strobes, only honoured in their own state
  logic start_accept;
  logic element_accept;

  // Current element is the last of the vector
  logic last_element;

  //////////////////////////////
  // Decode
  //////////////////////////////

  assign start_accept   = start && (state == ntm_diff_pkg::VEC_IDLE);
  assign element_accept = data_in_enable && (state == ntm_diff_pkg::VEC_WAIT_INPUT);
  assign last_element   = (index == length - ntm_diff_pkg::index_t'(1));

  //////////////////////////////
  // Control FSM
  //////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state           <= ntm_diff_pkg::VEC_IDLE;
      length          <= '0;
      index           <= '0;
      scalar_start    <= 1'b0;
      data_out        <= '0;
      data_out_enable <= 1'b0;
      ready           <= 1'b0;
    end else begin
      // Single-cycle pulses by default
      scalar_start    <= 1'b0;
      data_out_enable <= 1'b0;
      ready           <= 1'b0;

      case (state)
        ntm_diff_pkg::VEC_IDLE: begin
          if (start_accept) begin
            // Empty vector runs as one element
            if (size == '0) begin
              length <= ntm_diff_pkg::index_t'(1);
            end else begin
              length <= size;
            end
            index <= '0;
            state <= ntm_diff_pkg::VEC_WAIT_INPUT;
          end
        end

        ntm_diff_pkg::VEC_WAIT_INPUT: begin
          if (element_accept) begin
            // Operands are registered in the same edge
            scalar_start <= 1'b1;
            state        <= ntm_diff_pkg::VEC_WAIT_SCALAR;
          end
        end

        ntm_diff_pkg::VEC_WAIT_SCALAR: begin
          if (scalar_done) begin
            // Result register
            data_out        <= difference;
            data_out_enable <= 1'b1;
            if (last_element) begin
              ready <= 1'b1;
              state <= ntm_diff_pkg::VEC_IDLE;
            end else begin
              index <= index + ntm_diff_pkg::index_t'(1);
              state <= ntm_diff_pkg::VEC_WAIT_INPUT;
            end
          end
        end

        default: begin
          state <= ntm_diff_pkg::VEC_IDLE;
        end
      endcase
    end
  end

  //////////////////////////////
  // Operand registers
  //////////////////////////////

  always_ff @(posedge CLK) begin
    if (start_accept) begin
      modulus      <= modulo;
      // x[-1] is zero
      prev_element <= '0;
    end

    if (element_accept) begin
      // x[i] - x[i-1], held until scalar_done
      operands.modulo     <= modulus;
      operands.minuend    <= data_in;
      operands.subtrahend <= prev_element;
      // Becomes x[i-1] for the next step
      prev_element        <= data_in;
    end
  end

endmodule

// ==== source/ntm_scalar_mod_diff.sv ====
//////////////////////////////
// Scalar modular difference (a - b) mod m
// Both operands go through one bit-serial restoring remainder,
// result and done pulse come a fixed number of cycles after start
//////////////////////////////

`include "ntm_diff_params.svh"

module ntm_scalar_mod_diff (
  // Global
  input  logic                          CLK,
  input  logic                          RST,

  // Control
  input  logic                          scalar_start,
  output logic                          scalar_done,

  // Data
  input  ntm_diff_pkg::mod_operands_t   operands,
  output ntm_diff_pkg::data_t           difference
);

  //////////////////////////////
  // Constants
  //////////////////////////////

  localparam int W         = `NTM_DIFF_DATA_WIDTH;
  localparam int CNT_WIDTH = $clog2(W);

  // Index of the final dividend bit
  localparam logic [CNT_WIDTH-1:0] LAST_BIT = CNT_WIDTH'(W - 1);

  //////////////////////////////
  // Signals
  //////////////////////////////

  ntm_diff_pkg::scalar_state_e state;
  logic [CNT_WIDTH-1:0]        bit_cnt;
  logic                        last_bit;

  // Partial remainder, always below the modulus
  ntm_diff_pkg::data_t rem;
  // Dividend, shifted out MSB first
  ntm_diff_pkg::data_t dvd;
  // Minuend mod m, kept over the second pass
  ntm_diff_pkg::data_t red_minuend;

  // One restoring step
  logic [W:0]          trial;
  logic [W:0]          trial_sub;
  logic                trial_ge;
  ntm_diff_pkg::data_t rem_next;

  // Final combine
  ntm_diff_pkg::data_t raw_diff;
  ntm_diff_pkg::data_t mod_diff;

  //////////////////////////////
  // Remainder step
  //////////////////////////////

  // Shift next dividend bit into the remainder
  assign trial     = {rem, dvd[W-1]};
  assign trial_sub = trial - {1'b0, operands.modulo};
  assign trial_ge  = (trial >= {1'b0, operands.modulo});
  // Both choices are below m, upper bit is zero
  assign rem_next  = trial_ge ? trial_sub[W-1:0] : trial[W-1:0];

  assign last_bit  = (bit_cnt == LAST_BIT);

  // Wrap a negative difference back by adding m
  assign raw_diff  = red_minuend - rem;
  assign mod_diff  = (red_minuend >= rem) ? raw_diff : raw_diff + operands.modulo;

  //////////////////////////////
  // Control FSM
  //////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state       <= ntm_diff_pkg::SC_IDLE;
      bit_cnt     <= '0;
      scalar_done <= 1'b0;
    end else begin
      scalar_done <= 1'b0;

      case (state)
        ntm_diff_pkg::SC_IDLE: begin
          if (scalar_start) begin
            bit_cnt <= '0;
            state   <= ntm_diff_pkg::SC_REDUCE_MINUEND;
          end
        end

        ntm_diff_pkg::SC_REDUCE_MINUEND: begin
          bit_cnt <= last_bit ? '0 : bit_cnt + 1'b1;
          if (last_bit) begin
            state <= ntm_diff_pkg::SC_REDUCE_SUBTRAHEND;
          end
        end

        ntm_diff_pkg::SC_REDUCE_SUBTRAHEND: begin
          bit_cnt <= last_bit ? '0 : bit_cnt + 1'b1;
          if (last_bit) begin
            state <= ntm_diff_pkg::SC_COMBINE;
          end
        end

        ntm_diff_pkg::SC_COMBINE: begin
          scalar_done <= 1'b1;
          state       <= ntm_diff_pkg::SC_IDLE;
        end

        default: begin
          state <= ntm_diff_pkg::SC_IDLE;
        end
      endcase
    end
  end

  //////////////////////////////
  // Shared datapath
  //////////////////////////////

  always_ff @(posedge CLK) begin
    case (state)
      ntm_diff_pkg::SC_IDLE: begin
        // First pass on the minuend
        if (scalar_start) begin
          dvd <= operands.minuend;
          rem <= '0;
        end
      end

      ntm_diff_pkg::SC_REDUCE_MINUEND: begin
        if (last_bit) begin
          // Save result, reload for the subtrahend pass
          red_minuend <= rem_next;
          dvd         <= operands.subtrahend;
          rem         <= '0;
        end else begin
          dvd <= {dvd[W-2:0], 1'b0};
          rem <= rem_next;
        end
      end

      ntm_diff_pkg::SC_REDUCE_SUBTRAHEND: begin
        // Reduced subtrahend is left in rem
        dvd <= {dvd[W-2:0], 1'b0};
        rem <= rem_next;
      end

      ntm_diff_pkg::SC_COMBINE: begin
        difference <= mod_diff;
      end

      default: begin
        rem <= '0;
      end
    endcase
  end

endmodule

// ==== common/ntm_diff_pkg.sv ====
//////////////////////////////
// Shared types of the first-difference block
// Referenced by scoped name from the RTL and the testbench
//////////////////////////////

`include "ntm_diff_params.svh"

package ntm_diff_pkg;

  //////////////////////////////
  // Data types
  //////////////////////////////

  // One element, modulus or result
  typedef logic [`NTM_DIFF_DATA_WIDTH-1:0] data_t;

  // Vector length and element position
  typedef logic [`NTM_DIFF_INDEX_WIDTH-1:0] index_t;

  // Operand bundle from controller to scalar unit
  typedef struct packed {
    data_t modulo;
    data_t minuend;
    data_t subtrahend;
  } mod_operands_t;

  //////////////////////////////
  // FSM states
  //////////////////////////////

  // Vector controller
  typedef enum logic [1:0] {
    VEC_IDLE,
    VEC_WAIT_INPUT,
    VEC_WAIT_SCALAR
  } vec_state_e;

  // Scalar modular difference unit
  typedef enum logic [1:0] {
    SC_IDLE,
    SC_REDUCE_MINUEND,
    SC_REDUCE_SUBTRAHEND,
    SC_COMBINE
  } scalar_state_e;

endpackage

// ==== common/ntm_diff_params.svh ====
//////////////////////////////
// Widths and fixed latencies of the first-difference datapath
// Included by the package, the scalar unit and the testbench
//////////////////////////////

`ifndef NTM_DIFF_PARAMS_SVH
`define NTM_DIFF_PARAMS_SVH

// Element, modulus and result width
`define NTM_DIFF_DATA_WIDTH 32

// Vector length and element index width
`define NTM_DIFF_INDEX_WIDTH 16

// Cycles from scalar_start to scalar_done
// Two reductions, entry and combine cycles
`define NTM_DIFF_SCALAR_LATENCY (2 * `NTM_DIFF_DATA_WIDTH + 2)

// Cycles from data_in_enable to data_out_enable at the top level
`define NTM_DIFF_TOTAL_LATENCY (2 * `NTM_DIFF_DATA_WIDTH + 4)

`endif
